//--- img_settings.svh
`ifndef IMG_SETTINGS_SVH
`define IMG_SETTINGS_SVH

// Sensor frame geometry
`define IMG_WIDTH      16
`define IMG_HEIGHT     8
`define IMG_PIXELS     (`IMG_WIDTH * `IMG_HEIGHT)

// Readout stream layout, counted in 16-bit words
`define HEADER_WORDS   4
`define PADDING_WORDS  2

// Width of the highlight and shadow counters
`define STAT_WIDTH     18

// Thumbnail keeps the top-left THUMB_KEEP x THUMB_KEEP pixels of each group
`define THUMB_GROUP    8
`define THUMB_KEEP     2

// Statistics sample every STAT_GRID-th column and row
`define STAT_GRID      4

`endif

//--- img_pkg.sv
`default_nettype none

`include "img_settings.svh"

package img_pkg;

    // Raw sensor sample
    typedef logic [11:0] pixel_t;

    // Frame buffer and readout word
    typedef logic [15:0] word_t;

    typedef logic [$clog2(`IMG_PIXELS)-1:0]   buf_addr_t;
    typedef logic [$clog2(`IMG_PIXELS+1)-1:0] pixel_count_t;
    typedef logic [`STAT_WIDTH-1:0]           stat_count_t;

    // First header word sits in the top 16 bits
    typedef logic [`HEADER_WORDS*16-1:0] header_t;

    // Second Fletcher sum above the first
    typedef logic [31:0] checksum_t;

    // Pixel position inside the frame
    typedef logic [$clog2(`IMG_WIDTH)-1:0]  col_t;
    typedef logic [$clog2(`IMG_HEIGHT)-1:0] row_t;

endpackage

`default_nettype wire

//--- buf_if.sv
`default_nettype none

interface buf_if;
    import img_pkg::*;

    // Write side, one word per clock
    logic      wr_en;
    buf_addr_t wr_addr;
    word_t     wr_data;

    // Read side, data valid one cycle after the address
    buf_addr_t rd_addr;
    word_t     rd_data;

    modport writer (output wr_en, output wr_addr, output wr_data);

    modport reader (output rd_addr, input rd_data);

    modport mem (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

//--- fletcher32.sv
`default_nettype none

module fletcher32 (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 clear,
    input  wire                 en,
    input  wire img_pkg::word_t din,
    output img_pkg::checksum_t  sum
);
    import img_pkg::*;

    word_t sum_a;
    word_t sum_b;
    word_t next_a;
    word_t next_b;

    // Addition modulo 65535, operands already reduced except din
    function automatic word_t add_mod(input word_t x, input word_t y);
        logic [16:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    assign next_a = add_mod(sum_a, din);
    assign next_b = add_mod(sum_b, next_a);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            sum_b <= next_b;
        end
    end

    assign sum = {sum_b, sum_a};

endmodule

`default_nettype wire

//--- frame_capture.sv
`default_nettype none

`include "img_settings.svh"

module frame_capture (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cmd_capture,
    input  wire                   cmd_skip_count,
    input  wire img_pkg::pixel_t  img_d,
    input  wire                   img_fv,
    input  wire                   img_lv,
    buf_if.writer                 bus,
    output logic                  capture_done,
    output img_pkg::pixel_count_t pixel_count,
    output img_pkg::stat_count_t  highlight_count,
    output img_pkg::stat_count_t  shadow_count
);
    import img_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_SKIP,
        ST_STORE
    } cap_state_t;

    cap_state_t state;
    logic       cap_prev;
    logic       cap_change;
    logic       skip_left;

    pixel_t     d_q;
    logic       fv_q;
    logic       lv_q;
    logic       fv_prev;
    logic       lv_prev;
    col_t       col;
    row_t       row;
    logic       frame_start;
    logic       stat_hit;
    logic [6:0] top_bits;

    // ========================================
    // Sensor input registers
    // ========================================
    always_ff @(posedge clk) begin
        d_q <= img_d;
    end

    // Column follows d_q, row advances on each falling line valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            col     <= '0;
            row     <= '0;
        end else begin
            fv_q    <= img_fv;
            lv_q    <= img_lv;
            fv_prev <= fv_q;
            lv_prev <= lv_q;
            col     <= lv_q ? col + 1'b1 : '0;
            if (!fv_q) begin
                row <= '0;
            end else if (lv_prev && !lv_q) begin
                row <= row + 1'b1;
            end
        end
    end

    assign cap_change  = cmd_capture != cap_prev;
    assign frame_start = fv_q && !fv_prev;
    assign top_bits    = d_q[11:5];
    assign stat_hit    = ((int'(col) % `STAT_GRID) == 0) && ((int'(row) % `STAT_GRID) == 0);

    // Buffer write, low pixel byte first on the wire
    assign bus.wr_en   = (state == ST_STORE) && lv_q;
    assign bus.wr_addr = buf_addr_t'(pixel_count);
    assign bus.wr_data = {d_q[7:0], 4'b0000, d_q[11:8]};

    // ========================================
    // Capture FSM
    // ========================================
    // STORE is entered two cycles after frame valid rises,
    // so the first line must start later than that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            cap_prev        <= 1'b0;
            skip_left       <= 1'b0;
            capture_done    <= 1'b0;
            pixel_count     <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            cap_prev <= cmd_capture;

            case (state)
                ST_IDLE: begin
                end
                ST_WAIT: begin
                    if (frame_start) begin
                        state <= ST_SKIP;
                    end
                end
                ST_SKIP: begin
                    skip_left <= skip_left - 1'b1;
                    state     <= skip_left ? ST_WAIT : ST_STORE;
                end
                ST_STORE: begin
                    if (lv_q) begin
                        pixel_count <= pixel_count + 1'b1;
                        if (stat_hit && top_bits == '1) begin
                            highlight_count <= highlight_count + 1'b1;
                        end
                        if (stat_hit && top_bits == '0) begin
                            shadow_count <= shadow_count + 1'b1;
                        end
                    end
                    if (!fv_q) begin
                        capture_done <= ~capture_done;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            // A new command restarts even a capture in progress
            if (cap_change) begin
                pixel_count     <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
                skip_left       <= cmd_skip_count;
                state           <= ST_WAIT;
            end
        end
    end

    // A frame longer than the buffer would wrap onto stored pixels
    a_wr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.wr_en |-> pixel_count < pixel_count_t'(`IMG_PIXELS)
    ) else $error("frame_capture: write beyond frame buffer");

endmodule

`default_nettype wire

//--- frame_buffer.sv
`default_nettype none

`include "img_settings.svh"

module frame_buffer (
    input  wire clk,
    buf_if.mem  bus
);
    import img_pkg::*;

    // One word per pixel, raster order
    word_t mem [`IMG_PIXELS];

    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            mem[bus.wr_addr] <= bus.wr_data;
        end
        // Registered read, no enable
        bus.rd_data <= mem[bus.rd_addr];
    end

endmodule

`default_nettype wire

//--- readout_sequencer.sv
`default_nettype none

`include "img_settings.svh"

module readout_sequencer (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cmd_readout,
    input  wire img_pkg::header_t cmd_header,
    input  wire                   cmd_thumb,
    input  wire                   readout_trigger,
    buf_if.reader                 bus,
    output logic                  readout_ready,
    output img_pkg::word_t        readout_data
);
    import img_pkg::*;

    // Checksum word 0 goes straight to the output, the rest shift out
    localparam int TAIL_WORDS  = 2 + `PADDING_WORDS;
    localparam int SHIFT_WORDS = (`HEADER_WORDS > TAIL_WORDS) ? `HEADER_WORDS : TAIL_WORDS;
    localparam int SHIFT_BITS  = SHIFT_WORDS * 16;

    typedef logic [SHIFT_BITS-1:0]              shift_t;
    typedef logic [$clog2(SHIFT_WORDS+1)-1:0]   shift_cnt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PIXEL,
        ST_CSUM,
        ST_TAIL
    } seq_state_t;

    seq_state_t   state;
    logic         ro_prev;
    logic         ro_change;
    logic         thumb_q;
    shift_t       shift_sr;
    shift_cnt_t   shift_cnt;
    logic         shift_step;
    logic         csum_load;
    checksum_t    csum;

    pixel_count_t rd_ptr;
    logic         rd_valid;
    logic         hold_valid;
    word_t        hold_data;
    logic         keep;
    logic         ptr_done;
    logic         load;
    logic         consume;
    logic         issue;
    logic         advance;
    logic         xfer;

    assign ro_change = cmd_readout != ro_prev;

    // Output register may take a new word when empty or being drained
    assign load = !readout_ready || readout_trigger;
    assign xfer = readout_ready && readout_trigger;

    assign shift_step = (state == ST_HEADER || state == ST_TAIL) && load && shift_cnt != '0;
    assign csum_load  = (state == ST_CSUM) && !readout_ready;

    // ========================================
    // Checksum over transferred words
    // ========================================
    fletcher32 u_fletcher (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (ro_change),
        .en    (xfer),
        .din   ({readout_data[7:0], readout_data[15:8]}),
        .sum   (csum)
    );

    // ========================================
    // Pixel fetch
    // ========================================
    always_comb begin
        int col_i;
        int row_i;
        col_i = int'(rd_ptr) % `IMG_WIDTH;
        row_i = int'(rd_ptr) / `IMG_WIDTH;
        keep  = !thumb_q || ((col_i % `THUMB_GROUP) < `THUMB_KEEP &&
                             (row_i % `THUMB_GROUP) < `THUMB_KEEP);
    end

    assign ptr_done    = rd_ptr == pixel_count_t'(`IMG_PIXELS);
    assign bus.rd_addr = buf_addr_t'(rd_ptr);

    // At most one word waits behind the output register, returning or held
    assign consume = (state == ST_PIXEL) && load && (hold_valid || rd_valid);
    assign issue   = (state == ST_PIXEL) && !ptr_done && keep &&
                     (!(hold_valid || rd_valid) || consume);

    // Dropped thumbnail addresses are passed over one per cycle
    assign advance = (state == ST_PIXEL) && !ptr_done && (!keep || issue);

    always_ff @(posedge clk) begin
        if (rd_valid && !load) begin
            hold_data <= bus.rd_data;
        end
        if (ro_change) begin
            shift_sr <= shift_t'(cmd_header) << (SHIFT_BITS - `HEADER_WORDS * 16);
        end else if (csum_load) begin
            shift_sr <= shift_t'({csum[23:16], csum[31:24]}) << (SHIFT_BITS - 16);
        end else if (shift_step) begin
            shift_sr <= shift_sr << 16;
        end
    end

    // ========================================
    // Sequencer FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            ro_prev       <= 1'b0;
            thumb_q       <= 1'b0;
            shift_cnt     <= '0;
            rd_ptr        <= '0;
            rd_valid      <= 1'b0;
            hold_valid    <= 1'b0;
            readout_ready <= 1'b0;
            readout_data  <= '0;
        end else begin
            ro_prev  <= cmd_readout;
            rd_valid <= issue;
            if (advance) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                end
                ST_HEADER, ST_TAIL: begin
                    if (shift_step) begin
                        readout_data  <= shift_sr[SHIFT_BITS-1 -: 16];
                        readout_ready <= 1'b1;
                        shift_cnt     <= shift_cnt - 1'b1;
                    end else if (load) begin
                        readout_ready <= 1'b0;
                        state         <= (state == ST_HEADER) ? ST_PIXEL : ST_IDLE;
                    end
                end
                ST_PIXEL: begin
                    if (load) begin
                        readout_ready <= hold_valid || rd_valid;
                    end
                    if (consume) begin
                        readout_data <= hold_valid ? hold_data : bus.rd_data;
                    end
                    if (rd_valid && !load) begin
                        hold_valid <= 1'b1;
                    end else if (hold_valid && load) begin
                        hold_valid <= 1'b0;
                    end
                    if (ptr_done && !rd_valid && !hold_valid) begin
                        state <= ST_CSUM;
                    end
                end
                ST_CSUM: begin
                    // Sum is final once the last pixel has left
                    if (!readout_ready) begin
                        readout_data  <= {csum[7:0], csum[15:8]};
                        readout_ready <= 1'b1;
                        shift_cnt     <= shift_cnt_t'(TAIL_WORDS - 1);
                        state         <= ST_TAIL;
                    end else if (readout_trigger) begin
                        readout_ready <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (ro_change) begin
                thumb_q       <= cmd_thumb;
                shift_cnt     <= shift_cnt_t'(`HEADER_WORDS);
                rd_ptr        <= '0;
                rd_valid      <= 1'b0;
                hold_valid    <= 1'b0;
                readout_ready <= 1'b0;
                state         <= ST_HEADER;
            end
        end
    end

    // Back-pressure holds the offered word across all phases
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        readout_ready && !readout_trigger && !ro_change
            |=> readout_ready && $stable(readout_data)
    ) else $error("readout_sequencer: word changed under back-pressure");

endmodule

`default_nettype wire

//--- img_controller.sv
`default_nettype none

module img_controller (
    input  wire                   clk,
    input  wire                   rst_n,

    // Host commands
    input  wire                   cmd_capture,
    input  wire                   cmd_readout,
    input  wire                   cmd_skip_count,
    input  wire img_pkg::header_t cmd_header,
    input  wire                   cmd_thumb,

    // Sensor port
    input  wire img_pkg::pixel_t  img_d,
    input  wire                   img_fv,
    input  wire                   img_lv,

    // Readout stream
    input  wire                   readout_trigger,
    output logic                  readout_ready,
    output img_pkg::word_t        readout_data,

    // Capture status
    output logic                  capture_done,
    output img_pkg::pixel_count_t pixel_count,
    output img_pkg::stat_count_t  highlight_count,
    output img_pkg::stat_count_t  shadow_count
);

    buf_if frame_bus ();

    frame_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_capture     (cmd_capture),
        .cmd_skip_count  (cmd_skip_count),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .bus             (frame_bus),
        .capture_done    (capture_done),
        .pixel_count     (pixel_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    frame_buffer u_buffer (
        .clk (clk),
        .bus (frame_bus)
    );

    readout_sequencer u_readout (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .readout_trigger (readout_trigger),
        .bus             (frame_bus),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset released on a falling edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_img_controller.sv
`default_nettype none

`include "img_settings.svh"

module tb_img_controller;
    timeunit 1ns;
    timeprecision 100ps;
    import img_pkg::*;

    localparam int NUM_SCEN     = 7;
    localparam int WORD_TIMEOUT = 400;
    localparam int DONE_TIMEOUT = 100;
    localparam int IDLE_CYCLES  = 20;

    // Pixel sources for a frame
    localparam logic [1:0] MODE_RANDOM = 2'd0;
    localparam logic [1:0] MODE_ONES   = 2'd1;
    localparam logic [1:0] MODE_ZEROS  = 2'd2;
    localparam logic [1:0] MODE_MIXED  = 2'd3;

    typedef struct packed {
        logic        skip;
        logic        thumb;
        header_t     header;
        logic [6:0]  stall_pct;
        logic [31:0] pix_seed;
        logic [1:0]  pix_mode;
        logic [7:0]  exp_words;
    } scenario_t;

    logic         clk;
    logic         rst_n;
    logic         cmd_capture;
    logic         cmd_readout;
    logic         cmd_skip_count;
    header_t      cmd_header;
    logic         cmd_thumb;
    pixel_t       img_d;
    logic         img_fv;
    logic         img_lv;
    logic         readout_trigger;
    logic         readout_ready;
    word_t        readout_data;
    logic         capture_done;
    pixel_count_t pixel_count;
    stat_count_t  highlight_count;
    stat_count_t  shadow_count;

    scenario_t    scen [NUM_SCEN];
    pixel_t       frame_pix [`IMG_PIXELS];
    word_t        exp_q [$];
    word_t        got_q [$];
    logic [31:0]  rng;
    int           exp_high;
    int           exp_shadow;

    tb_clock_gen u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    img_controller DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_capture     (cmd_capture),
        .cmd_readout     (cmd_readout),
        .cmd_skip_count  (cmd_skip_count),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .readout_trigger (readout_trigger),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .capture_done    (capture_done),
        .pixel_count     (pixel_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_with_failure({"wrong value on ", name});
        end
    endtask

    // Rows: skip, thumb, header, stall percent, pixel seed, pixel mode, word count
    task automatic load_scenarios();
        scen[0] = '{1'b0, 1'b0, 64'hA5A5_0001_1234_5678, 7'd0,  32'h0000_0000,
                    MODE_RANDOM, 8'd136};
        scen[1] = '{1'b1, 1'b0, 64'h0102_0304_0506_0708, 7'd0,  32'h0000_1F2E,
                    MODE_MIXED, 8'd136};
        scen[2] = '{1'b0, 1'b1, 64'hFFFF_0000_8001_7FFE, 7'd0,  32'h00C0_FFEE,
                    MODE_MIXED, 8'd16};
        scen[3] = '{1'b1, 1'b0, 64'hDEAD_BEEF_CAFE_F00D, 7'd40, 32'h0BAD_5EED,
                    MODE_MIXED, 8'd136};
        scen[4] = '{1'b0, 1'b1, 64'h1357_9BDF_2468_ACE0, 7'd60, 32'h0000_0077,
                    MODE_RANDOM, 8'd16};
        scen[5] = '{1'b0, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 7'd25, 32'h0000_0000,
                    MODE_ONES, 8'd136};
        scen[6] = '{1'b0, 1'b0, 64'h0000_0000_0000_0001, 7'd0,  32'h0000_0000,
                    MODE_ZEROS, 8'd136};
    endtask

    // ========================================
    // Sensor model
    // ========================================
    task automatic make_frame(input logic [1:0] mode);
        for (int i = 0; i < `IMG_PIXELS; i++) begin
            rng = lcg_step(rng);
            case (mode)
                MODE_ONES:  frame_pix[i] = 12'hFFF;
                MODE_ZEROS: frame_pix[i] = 12'h000;
                MODE_MIXED: begin
                    // Roughly a quarter highlights and a quarter shadows
                    if (rng[29:28] == 2'd0) begin
                        frame_pix[i] = {7'h7F, rng[20:16]};
                    end else if (rng[29:28] == 2'd1) begin
                        frame_pix[i] = {7'h00, rng[20:16]};
                    end else begin
                        frame_pix[i] = rng[27:16];
                    end
                end
                default: frame_pix[i] = rng[27:16];
            endcase
        end
    endtask

    // First line starts well after the DUT has seen frame valid rise
    task automatic drive_frame();
        @(negedge clk);
        img_fv = 1'b1;
        repeat (4) @(negedge clk);
        for (int r = 0; r < `IMG_HEIGHT; r++) begin
            for (int c = 0; c < `IMG_WIDTH; c++) begin
                img_lv = 1'b1;
                img_d  = frame_pix[r * `IMG_WIDTH + c];
                @(negedge clk);
            end
            img_lv = 1'b0;
            img_d  = '0;
            repeat (3) @(negedge clk);
        end
        img_fv = 1'b0;
        repeat (6) @(negedge clk);
    endtask

    task automatic wait_capture_done(input logic done_prev);
        int cnt;
        cnt = 0;
        while (capture_done === done_prev) begin
            @(negedge clk);
            cnt++;
            if (cnt > DONE_TIMEOUT) begin
                stop_with_failure("capture_done did not toggle after the frame ended");
            end
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    task automatic build_expected(input logic thumb, input header_t header);
        int    a;
        int    b;
        int    col;
        int    row;
        word_t w;
        word_t s;
        logic [15:0] a16;
        logic [15:0] b16;
        exp_q.delete();
        a          = 0;
        b          = 0;
        exp_high   = 0;
        exp_shadow = 0;
        for (int i = 0; i < `HEADER_WORDS; i++) begin
            exp_q.push_back(header[(`HEADER_WORDS - i) * 16 - 1 -: 16]);
        end
        for (int i = 0; i < `IMG_PIXELS; i++) begin
            col = i % `IMG_WIDTH;
            row = i / `IMG_WIDTH;
            if ((col % `STAT_GRID) == 0 && (row % `STAT_GRID) == 0) begin
                if (frame_pix[i][11:5] == 7'h7F) exp_high++;
                if (frame_pix[i][11:5] == 7'h00) exp_shadow++;
            end
            if (!thumb || ((col % `THUMB_GROUP) < `THUMB_KEEP &&
                           (row % `THUMB_GROUP) < `THUMB_KEEP)) begin
                exp_q.push_back({frame_pix[i][7:0], 4'b0000, frame_pix[i][11:8]});
            end
        end
        // Fletcher-32 over byte-swapped header and pixel words
        foreach (exp_q[i]) begin
            w = exp_q[i];
            s = {w[7:0], w[15:8]};
            a = (a + int'(s)) % 65535;
            b = (b + a) % 65535;
        end
        a16 = a[15:0];
        b16 = b[15:0];
        exp_q.push_back({a16[7:0], a16[15:8]});
        exp_q.push_back({b16[7:0], b16[15:8]});
        for (int i = 0; i < `PADDING_WORDS; i++) begin
            exp_q.push_back(16'h0000);
        end
    endtask

    // ========================================
    // Readout host
    // ========================================
    // Words are taken at the falling edge where the trigger is raised
    task automatic collect_stream(input int stall_pct, input int n_words);
        int    wait_cnt;
        int    r;
        logic  trig;
        logic  prev_stall;
        word_t prev_data;
        got_q.delete();
        wait_cnt   = 0;
        prev_stall = 1'b0;
        prev_data  = '0;
        while (got_q.size() < n_words) begin
            @(negedge clk);
            if (prev_stall) begin
                check_value("readout_ready", 64'(readout_ready), 64'(1));
                check_value("readout_data", 64'(readout_data), 64'(prev_data));
            end
            rng  = lcg_step(rng);
            r    = int'(rng[30:16]);
            trig = (r % 100) >= stall_pct;
            readout_trigger = trig;
            if (readout_ready && trig) begin
                got_q.push_back(readout_data);
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                if (wait_cnt > WORD_TIMEOUT) begin
                    stop_with_failure("no readout word was transferred while words were due");
                end
            end
            prev_stall = readout_ready && !trig;
            prev_data  = readout_data;
        end
    endtask

    task automatic check_idle_after_stream();
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            readout_trigger = 1'b0;
            check_value("readout_ready after stream end", 64'(readout_ready), 64'(0));
        end
    endtask

    task automatic run_scenario(input int idx, input scenario_t sc);
        logic done_prev;
        rng = rng ^ sc.pix_seed;

        @(negedge clk);
        cmd_skip_count = sc.skip;
        cmd_capture    = ~cmd_capture;
        done_prev      = capture_done;
        repeat (3) @(negedge clk);

        // Skipped frames first, the last frame driven is the stored one
        for (int f = 0; f <= int'(sc.skip); f++) begin
            make_frame(sc.pix_mode);
            drive_frame();
        end
        wait_capture_done(done_prev);

        build_expected(sc.thumb, sc.header);
        check_value("pixel_count", 64'(pixel_count), 64'(`IMG_PIXELS));
        check_value("highlight_count", 64'(highlight_count), 64'(exp_high));
        check_value("shadow_count", 64'(shadow_count), 64'(exp_shadow));
        check_value("expected word count", 64'(exp_q.size()), 64'(sc.exp_words));

        @(negedge clk);
        cmd_header  = sc.header;
        cmd_thumb   = sc.thumb;
        cmd_readout = ~cmd_readout;
        collect_stream(int'(sc.stall_pct), exp_q.size());
        foreach (exp_q[i]) begin
            check_value($sformatf("readout_data word %0d", i), 64'(got_q[i]), 64'(exp_q[i]));
        end
        check_idle_after_stream();
        $display("Scenario %0d done, %0d words", idx, got_q.size());
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int cnt;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_skip_count  = 1'b0;
        cmd_header      = '0;
        cmd_thumb       = 1'b0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        rng             = 32'd3686;
        cnt             = 0;
        load_scenarios();

        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cnt++;
            if (cnt > 50) begin
                stop_with_failure("reset was never released");
            end
        end
        @(negedge clk);
        check_value("readout_ready", 64'(readout_ready), 64'(0));
        check_value("capture_done", 64'(capture_done), 64'(0));
        check_value("pixel_count", 64'(pixel_count), 64'(0));
        check_value("highlight_count", 64'(highlight_count), 64'(0));
        check_value("shadow_count", 64'(shadow_count), 64'(0));

        for (int s = 0; s < NUM_SCEN; s++) begin
            run_scenario(s, scen[s]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
img_pkg.sv
buf_if.sv
fletcher32.sv
frame_capture.sv
frame_buffer.sv
readout_sequencer.sv
img_controller.sv
tb_clock_gen.sv
tb_img_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_img_controller
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard *.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
